/* Makefile */
# Verilator build and run of the prefetch FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_prefetch_fifo
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   ?= obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' build.f)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): build.f $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f build.f

# pass only when the run prints the pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
src/pfifo_pkg.sv
src/sdp_ram.sv
src/fifo_ctrl.sv
src/reg_fifo.sv
src/prefetch_fifo.sv
sim/prefetch_fifo_assert.sv
sim/tb_prefetch_fifo.sv

/* sim/fifo_patterns.txt */
# W word(hex) | R count stall_pct | Q settle | D word(hex) cycles, write while full
# E rd_vld almost_full almost_empty wr_level rd_level, checked after Q
Q
E 0 0 1 0 0
W a0000001
Q
E 1 0 1 0 0
R 1 0
W b0000000
W b0000001
W b0000002
W b0000003
W b0000004
W b0000005
W b0000006
W b0000007
W b0000008
W b0000009
W b000000a
W b000000b
W b000000c
W b000000d
W b000000e
W b000000f
W b0000010
W b0000011
Q
E 1 1 0 16 16
D deadbeef 6
Q
E 1 1 0 16 16
R 12 30
W c0000001
W c0000002
W c0000003
R 4 50
Q
E 1 0 0 3 3
R 5 25
Q
E 0 0 1 0 0

/* sim/prefetch_fifo_assert.sv */
////////////////////
// concurrent checks on the prefetch path
////////////////////

`timescale 1ns/1ps

module prefetch_fifo_assert (
  input logic                         rd_clk,
  input logic                         rd_rst,
  input logic                         ram_vld,   // RAM word lands in reg_fifo
  input logic                         in_ready,  // reg_fifo has room
  input logic                         ram_rd,
  input logic [pfifo_pkg::lvl_w-1:0]  rd_level,  // words left in the RAM
  input logic [pfifo_pkg::cred_w-1:0] credits,
  input logic                         rd_vld,
  input logic                         rd_en,
  input logic [pfifo_pkg::data_w-1:0] rd_data
);

  import pfifo_pkg::*;

  int fail_cnt = 0;  // assertion failures so far

  no_overflow: assert property (@(posedge rd_clk) disable iff (rd_rst)
    ram_vld |-> in_ready)
    else
    begin
      fail_cnt++;
      $error("RAM word arrived while reg_fifo had no room");
    end

  credit_bound: assert property (@(posedge rd_clk) disable iff (rd_rst)
    credits <= cred_w'(pf_depth))
    else
    begin
      fail_cnt++;
      $error("credit count above the register FIFO depth");
    end

  hold_on_stall: assert property (@(posedge rd_clk) disable iff (rd_rst)
    (rd_vld && !rd_en) |=> $stable(rd_data))
    else
    begin
      fail_cnt++;
      $error("rd_data changed while stalled");
    end

  // empty flag and level come from separate pointer compares
  no_read_empty: assert property (@(posedge rd_clk) disable iff (rd_rst)
    ram_rd |-> (rd_level != '0))
    else
    begin
      fail_cnt++;
      $error("RAM read issued while empty");
    end

endmodule

bind prefetch_fifo prefetch_fifo_assert chk0 (
  .rd_clk   (rd_clk),
  .rd_rst   (rd_rst),
  .ram_vld  (ram_vld),
  .in_ready (pf0.in_ready),
  .ram_rd   (ram_rd),
  .rd_level (rd_level),
  .credits  (credits),
  .rd_vld   (rd_vld),
  .rd_en    (rd_en),
  .rd_data  (rd_data)
);

/* sim/tb_prefetch_fifo.sv */
////////////////////
// testbench for prefetch_fifo with clocks, reset, pattern
// commands, scoreboard queue, checks and timeout
////////////////////

`timescale 1ns/1ps

module tb_prefetch_fifo;

  import pfifo_pkg::*;

  logic              wr_clk;
  logic              rd_clk;
  logic              rd_rst;
  logic [data_w-1:0] wr_data;
  logic              wr_en;
  logic              wr_vld;
  logic              rd_en;
  logic [data_w-1:0] rd_data;
  logic              rd_vld;
  logic              almost_full;
  logic              almost_empty;
  logic [lvl_w-1:0]  wr_level;
  logic [lvl_w-1:0]  rd_level;

  logic [7:0]        op [256];      // command letters
  logic [31:0]       arg [256][5];  // command operands
  int                n_ops;
  logic [31:0]       exp_q [$];     // written, not yet popped
  int                err_cnt = 0;
  int                chk_cnt = 0;
  int                cycles = 0;    // rd_clk cycles since start
  int                limit = 0;     // zero until the patterns are loaded
  bit                wr_aligned = 1'b0;  // already at wr_clk edge plus 0.5 ns

  prefetch_fifo dut0 (
    .wr_clk       (wr_clk),
    .wr_data      (wr_data),
    .wr_en        (wr_en),
    .wr_vld       (wr_vld),
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .rd_en        (rd_en),
    .rd_data      (rd_data),
    .rd_vld       (rd_vld),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .wr_level     (wr_level),
    .rd_level     (rd_level)
  );

  ////////////////////
  // clocks and timeout
  ////////////////////

  initial
  begin
    rd_clk = 1'b0;
    forever #2 rd_clk = ~rd_clk;  // 4 ns
  end

  initial
  begin
    wr_clk = 1'b0;
    forever #3 wr_clk = ~wr_clk;  // 6 ns period
  end

  always @(posedge rd_clk)
  begin
    cycles++;
    if (limit != 0 && cycles >= limit)
    begin
      $display("timeout: run still busy after %0d rd_clk cycles", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_patterns(output bit ok);
    int          fd;
    int          c;
    int          total;
    logic [7:0]  ch;
    logic [31:0] a [5];
    fd    = $fopen("sim/fifo_patterns.txt", "r");
    ok    = (fd != 0);
    n_ops = 0;
    total = 0;
    if (ok)
    begin
      while ($fscanf(fd, " %c", ch) == 1)
      begin
        if (ch == "#")
        begin
          c = $fgetc(fd);  // drop the rest of a comment line
          while (c != 10 && c != -1)
            c = $fgetc(fd);
        end
        else
        begin
          a = '{default: '0};
          case (ch)
            "W":
            begin
              c     = $fscanf(fd, "%h", a[0]);
              total = total + 1;
            end
            "D":
            begin
              c     = $fscanf(fd, "%h %d", a[0], a[1]);
              total = total + int'(a[1]);  // one wr_clk per probe cycle
            end
            "R":
            begin
              c     = $fscanf(fd, "%d %d", a[0], a[1]);
              total = total + int'(a[0]);
            end
            "E": c = $fscanf(fd, "%d %d %d %d %d", a[0], a[1], a[2], a[3], a[4]);
            default: c = 0;  // Q takes no operands
          endcase
          op[n_ops]  = ch;
          arg[n_ops] = a;
          n_ops++;
        end
      end
      $fclose(fd);
    end
    limit = 50 * total + 1000;
  endtask

  task automatic write_word(input logic [31:0] word);
    if (!wr_aligned)
    begin
      @(posedge wr_clk);
      #0.5;
    end
    wr_en   = 1'b1;
    wr_data = word;
    while (!wr_vld)  // writer holds the word while full
    begin
      @(posedge wr_clk);
      #0.5;
    end
    @(posedge wr_clk);  // accepted on this edge
    #0.5;
    wr_en = 1'b0;
    exp_q.push_back(word);
    wr_aligned = 1'b1;
  endtask

  task automatic drop_probe(input logic [31:0] word, input logic [31:0] n);
    if (!wr_aligned)
    begin
      @(posedge wr_clk);
      #0.5;
    end
    wr_en   = 1'b1;  // ignored by the DUT and never queued
    wr_data = word;
    repeat (n)
    begin
      check_value(32'(wr_vld), 32'd0, "wr_vld during dropped write");
      @(posedge wr_clk);
      #0.5;
    end
    wr_en      = 1'b0;
    wr_aligned = 1'b1;
  endtask

  task automatic read_words(input logic [31:0] n, input logic [31:0] pct);
    logic [31:0] held;
    logic        was_vld;
    logic [31:0] done;
    done = '0;
    @(posedge rd_clk);
    #0.5;
    while (done < n)
    begin
      if (!rd_vld || ($urandom % 100) < pct)
      begin
        rd_en   = 1'b0;  // stall or nothing to take yet
        held    = rd_data;
        was_vld = rd_vld;
        @(posedge rd_clk);
        #0.5;
        if (was_vld)
          check_value(rd_data, held, "rd_data under back-pressure");
      end
      else
      begin
        rd_en = 1'b1;  // pop on the next edge
        if (exp_q.size() == 0)
        begin
          err_cnt++;
          $display("rd_vld high with no written word left to pop");
        end
        else
          check_value(rd_data, exp_q.pop_front(), "rd_data");
        done++;
        @(posedge rd_clk);
        #0.5;
      end
    end
    rd_en      = 1'b0;
    wr_aligned = 1'b0;
  endtask

  task automatic settle();
    repeat (20) @(posedge rd_clk);
    #0.5;
    wr_aligned = 1'b0;
  endtask

  // RAM holds the outstanding words minus up to pf_depth prefetched
  task automatic check_status(input int i);
    int ram_words;
    ram_words = exp_q.size() - ((exp_q.size() < pf_depth) ? exp_q.size() : pf_depth);
    check_value(32'(rd_vld), arg[i][0], "rd_vld");
    check_value(32'(almost_full), arg[i][1], "almost_full");
    check_value(32'(almost_empty), arg[i][2], "almost_empty");
    check_value(32'(wr_level), arg[i][3], "wr_level");
    check_value(32'(rd_level), arg[i][4], "rd_level");
    check_value(32'(wr_vld), (ram_words < ram_depth) ? 32'd1 : 32'd0, "wr_vld");
  endtask

  task automatic run_op(input int i);
    case (op[i])
      "W": write_word(arg[i][0]);
      "D": drop_probe(arg[i][0], arg[i][1]);
      "R": read_words(arg[i][0], arg[i][1]);
      "Q": settle();
      "E": check_status(i);
      default:
      begin
        err_cnt++;
        $display("unknown command in pattern entry %0d", i);
      end
    endcase
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial
  begin
    bit ok;
    rd_rst  = 1'b1;
    wr_en   = 1'b0;
    wr_data = '0;
    rd_en   = 1'b0;
    void'($urandom(32'h9467_ddba));  // seeds the read stalls
    load_patterns(ok);
    repeat (3) @(posedge rd_clk);
    #0.5;
    rd_rst = 1'b0;
    if (!ok)
    begin
      $display("pattern file sim/fifo_patterns.txt could not be opened");
      $display("Regression failed");
      $finish;
    end
    else
    begin
      for (int i = 0; i < n_ops; i++)
        run_op(i);
      check_value(32'(exp_q.size()), 32'd0, "words left after drain");
      check_value(32'(rd_vld), 32'd0, "rd_vld after drain");
      $display("checks %0d, errors %0d, assertion failures %0d", chk_cnt, err_cnt,
               dut0.chk0.fail_cnt);
      if (err_cnt == 0 && dut0.chk0.fail_cnt == 0)
        $display("Regression passed");
      else
        $display("Regression failed");
      $finish;
    end
  end

endmodule

/* src/fifo_ctrl.sv */
////////////////////
// dual-clock pointer controller: Gray pointers, two-flop syncs,
// write reset sync, full/empty, levels and almost flags
////////////////////

`timescale 1ns/1ps

module fifo_ctrl (
  input  logic                         wr_clk,        // write clock
  input  logic                         rd_clk,        // read clock
  input  logic                         rd_rst,        // async reset, both domains
  input  logic                         wr_go,         // accepted write
  input  logic                         rd_go,         // RAM read issued
  output logic [pfifo_pkg::addr_w-1:0] waddr,         // RAM write address
  output logic [pfifo_pkg::addr_w-1:0] raddr,         // RAM read address
  output logic                         full,          // write side full
  output logic                         empty,         // read side empty
  output logic                         almost_full,   // write domain
  output logic                         almost_empty,  // read domain
  output logic [pfifo_pkg::lvl_w-1:0]  wr_level,      // words seen by writer
  output logic [pfifo_pkg::lvl_w-1:0]  rd_level       // words seen by reader
);

  import pfifo_pkg::*;

  function automatic logic [addr_w:0] bin2gray(input logic [addr_w:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [addr_w:0] gray2bin(input logic [addr_w:0] g);
    logic [addr_w:0] b;
    b[addr_w] = g[addr_w];
    for (int i = addr_w - 1; i >= 0; i--)
    begin
      b[i] = b[i+1] ^ g[i];  // running xor from the msb down
    end
    return b;
  endfunction

  logic [1:0]      wr_rst_q;   // write reset synchronizer
  logic            wr_rst;     // write domain reset, sync release

  logic [addr_w:0] wbin;       // write pointer, binary
  logic [addr_w:0] wgray;      // write pointer, gray
  logic [addr_w:0] wbin_next;
  logic [addr_w:0] wgray_next;
  logic [addr_w:0] rq1;        // read gray, first sync stage
  logic [addr_w:0] rq2;        // read gray in wr_clk domain
  logic [addr_w:0] rbin_w;     // read pointer seen by writer
  logic            full_next;

  logic [addr_w:0] rbin;       // read pointer, binary
  logic [addr_w:0] rgray;      // read pointer, gray
  logic [addr_w:0] rbin_next;
  logic [addr_w:0] wq1;        // write gray, first sync stage
  logic [addr_w:0] wq2;        // write gray in rd_clk domain
  logic [addr_w:0] wbin_r;     // write pointer seen by reader

  ////////////////////
  // write reset
  ////////////////////

  always_ff @(posedge wr_clk or posedge rd_rst)
  begin
    if (rd_rst)
      wr_rst_q <= 2'b11;
    else
      wr_rst_q <= {wr_rst_q[0], 1'b0};  // release after two wr_clk edges
  end

  assign wr_rst = wr_rst_q[1];

  ////////////////////
  // write domain
  ////////////////////

  assign wbin_next  = wbin + {{addr_w{1'b0}}, wr_go};
  assign wgray_next = bin2gray(wbin_next);

  // full when next pointer laps the synced read pointer
  assign full_next = (wgray_next == {~rq2[addr_w:addr_w-1], rq2[addr_w-2:0]});

  always_ff @(posedge wr_clk or posedge wr_rst)
  begin
    if (wr_rst)
    begin
      wbin  <= '0;
      wgray <= '0;
      rq1   <= '0;
      rq2   <= '0;
    end
    else
    begin
      wbin  <= wbin_next;
      wgray <= wgray_next;
      rq1   <= rgray;  // crossing from rd_clk
      rq2   <= rq1;
    end
  end

  // full clears in step with the last reset sync stage
  always_ff @(posedge wr_clk or posedge rd_rst)
  begin
    if (rd_rst)
      full <= 1'b1;  // no writes until the write side is out of reset
    else
      full <= wr_rst_q[0] | full_next;
  end

  assign waddr       = wbin[addr_w-1:0];
  assign rbin_w      = gray2bin(rq2);
  assign wr_level    = wbin - rbin_w;  // pessimistic by the sync delay
  assign almost_full = (wr_level >= lvl_w'(almost_full_lvl));

  ////////////////////
  // read domain
  ////////////////////

  assign rbin_next = rbin + {{addr_w{1'b0}}, rd_go};

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      rbin  <= '0;
      rgray <= '0;
      wq1   <= '0;
      wq2   <= '0;
    end
    else
    begin
      rbin  <= rbin_next;
      rgray <= bin2gray(rbin_next);
      wq1   <= wgray;  // crossing from wr_clk
      wq2   <= wq1;
    end
  end

  assign empty        = (rgray == wq2);  // both registered, safe to compare
  assign raddr        = rbin[addr_w-1:0];
  assign wbin_r       = gray2bin(wq2);
  assign rd_level     = wbin_r - rbin;
  assign almost_empty = (rd_level <= lvl_w'(almost_empty_lvl));

endmodule

/* src/pfifo_pkg.sv */
////////////////////
// shared widths, depths and level thresholds
// for the dual-clock prefetch FIFO
////////////////////

package pfifo_pkg;

  ////////////////////
  // data path
  ////////////////////

  localparam int data_w    = 32;          // data word width
  localparam int addr_w    = 4;           // RAM address width
  localparam int ram_depth = 1 << addr_w; // 16 RAM words

  ////////////////////
  // levels
  ////////////////////

  // one extra bit so a level can reach ram_depth
  localparam int lvl_w = addr_w + 1;

  localparam int almost_full_lvl  = 14;   // wr_level at or above this
  localparam int almost_empty_lvl = 2;    // rd_level at or below this

  ////////////////////
  // prefetch buffer
  ////////////////////

  localparam int pf_depth = 2;            // register FIFO entries

  // credit and entry counters must hold 0 to pf_depth
  localparam int cred_w = $clog2(pf_depth + 1);

endpackage

/* src/prefetch_fifo.sv */
////////////////////
// dual-clock prefetch FIFO top: write gating, prefetch issue,
// in-flight credits, RAM, controller and register FIFO
////////////////////

`timescale 1ns/1ps

module prefetch_fifo (
  input  logic                         wr_clk,        // write clock
  input  logic [pfifo_pkg::data_w-1:0] wr_data,       // write word
  input  logic                         wr_en,         // write request
  output logic                         wr_vld,        // write accepted when high
  input  logic                         rd_clk,        // read clock
  input  logic                         rd_rst,        // async reset, both domains
  input  logic                         rd_en,         // consume head word
  output logic [pfifo_pkg::data_w-1:0] rd_data,       // valid with rd_vld
  output logic                         rd_vld,        // head word present
  output logic                         almost_full,   // write domain
  output logic                         almost_empty,  // read domain
  output logic [pfifo_pkg::lvl_w-1:0]  wr_level,
  output logic [pfifo_pkg::lvl_w-1:0]  rd_level
);

  import pfifo_pkg::*;

  logic [addr_w-1:0] waddr;
  logic [addr_w-1:0] raddr;
  logic              full;
  logic              empty;
  logic              wr_go;    // accepted write
  logic              ram_rd;   // RAM read enable
  logic              ram_vld;  // RAM word arrives this cycle
  logic [data_w-1:0] ram_q;    // RAM read data
  logic              pop;      // word leaves the read port
  logic [cred_w-1:0] credits;  // buffered plus in-flight words

  assign wr_vld = ~full;
  assign wr_go  = wr_en & wr_vld;  // wr_en while full is dropped
  assign pop    = rd_vld & rd_en;

  // fetch ahead while a slot is free or frees this cycle
  assign ram_rd = ~empty & ((credits < cred_w'(pf_depth)) |
                            ((credits == cred_w'(pf_depth)) & pop));

  ////////////////////
  // prefetch issue
  ////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      ram_vld <= 1'b0;
      credits <= '0;
    end
    else
    begin
      ram_vld <= ram_rd;  // lines up with ram_q
      case ({ram_rd, pop})
        2'b10:   credits <= credits + cred_w'(1);
        2'b01:   credits <= credits - cred_w'(1);
        default: credits <= credits;  // both or neither
      endcase
    end
  end

  ////////////////////
  // blocks
  ////////////////////

  sdp_ram ram0 (
    .wr_clk (wr_clk),
    .we     (wr_go),
    .waddr  (waddr),
    .wdata  (wr_data),
    .rd_clk (rd_clk),
    .re     (ram_rd),
    .raddr  (raddr),
    .rdata  (ram_q)
  );

  fifo_ctrl ctrl0 (
    .wr_clk       (wr_clk),
    .rd_clk       (rd_clk),
    .rd_rst       (rd_rst),
    .wr_go        (wr_go),
    .rd_go        (ram_rd),
    .waddr        (waddr),
    .raddr        (raddr),
    .full         (full),
    .empty        (empty),
    .almost_full  (almost_full),
    .almost_empty (almost_empty),
    .wr_level     (wr_level),
    .rd_level     (rd_level)
  );

  reg_fifo pf0 (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .in_valid  (ram_vld),
    .in_data   (ram_q),
    .in_ready  (),         // credits guarantee room
    .out_ready (rd_en),
    .out_data  (rd_data),
    .out_valid (rd_vld)
  );

endmodule

/* src/reg_fifo.sv */
////////////////////
// two-entry register FIFO, first word fall through
////////////////////

`timescale 1ns/1ps

module reg_fifo (
  input  logic                         rd_clk,     // read clock
  input  logic                         rd_rst,     // async reset
  input  logic                         in_valid,   // word from RAM
  input  logic [pfifo_pkg::data_w-1:0] in_data,
  output logic                         in_ready,   // room for a word
  input  logic                         out_ready,  // consumer takes head
  output logic [pfifo_pkg::data_w-1:0] out_data,   // head register
  output logic                         out_valid   // head holds a word
);

  import pfifo_pkg::*;

  logic [data_w-1:0] head;   // oldest entry
  logic [data_w-1:0] tail;   // second entry
  logic [cred_w-1:0] count;  // entries held
  logic              push;
  logic              pop;

  assign out_valid = (count != '0);
  assign out_data  = head;
  assign in_ready  = (count < cred_w'(pf_depth)) | out_ready;  // full but popping
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  ////////////////////
  // occupancy
  ////////////////////

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
      count <= '0;
    else if (push & ~pop)
      count <= count + cred_w'(1);
    else if (pop & ~push)
      count <= count - cred_w'(1);
  end

  ////////////////////
  // entries
  ////////////////////

  always_ff @(posedge rd_clk)
  begin
    case (count)
      cred_w'(0):
      begin
        if (push)
          head <= in_data;  // straight to head
      end
      cred_w'(1):
      begin
        if (push & pop)
          head <= in_data;  // replace the leaving word
        else if (push)
          tail <= in_data;
      end
      default:
      begin
        if (pop)
        begin
          head <= tail;     // shift forward
          if (push)
            tail <= in_data;
        end
      end
    endcase
  end

endmodule

/* src/sdp_ram.sv */
////////////////////
// simple dual-port RAM, write on wr_clk,
// clock-enabled registered read on rd_clk
////////////////////

`timescale 1ns/1ps

module sdp_ram (
  input  logic                        wr_clk,  // write clock
  input  logic                        we,      // write enable
  input  logic [pfifo_pkg::addr_w-1:0] waddr,  // write address
  input  logic [pfifo_pkg::data_w-1:0] wdata,  // write data
  input  logic                        rd_clk,  // read clock
  input  logic                        re,      // read clock enable
  input  logic [pfifo_pkg::addr_w-1:0] raddr,  // read address
  output logic [pfifo_pkg::data_w-1:0] rdata   // read data, one cycle after re
);

  import pfifo_pkg::*;

  logic [data_w-1:0] mem [ram_depth];  // storage array, block RAM style

  ////////////////////
  // write port
  ////////////////////

  always_ff @(posedge wr_clk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;  // plain word write
    end
  end

  ////////////////////
  // read port
  ////////////////////

  always_ff @(posedge rd_clk)
  begin
    if (re)
    begin
      rdata <= mem[raddr];  // holds between enables
    end
  end

endmodule
